/* rtl/lc4_isa_pkg.sv */
//##########################################################
// LC4 instruction set definitions for the reduced core
// Word and register select widths, opcodes of ADD, AND,
// CONST and BR, and the two decodings of an instruction
//##########################################################
`default_nettype none

package lc4_isa_pkg;

  localparam int WORD_W    = 16;
  localparam int REG_SEL_W = 3;
  localparam int NUM_REGS  = 8;

  // Opcode in bits 15:12
  localparam logic [3:0] OP_BR    = 4'b0000;
  localparam logic [3:0] OP_ADD   = 4'b0001;
  localparam logic [3:0] OP_AND   = 4'b0101;
  localparam logic [3:0] OP_CONST = 4'b1001;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_SEL_W-1:0] reg_sel_t;

  // Register-form ALU layout
  // Low field is sub-op plus rt when imm_flag is clear, else imm5
  typedef struct packed {
    logic [3:0] opcode;
    reg_sel_t   rd;
    reg_sel_t   rs;
    logic       imm_flag;
    logic [4:0] low;
  } alu_view_t;

  // CONST and BR layout
  // Field is rd for CONST and the n/z/p mask for BR
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] field;
    logic [8:0] imm9;
  } wide_view_t;

  typedef union packed {
    alu_view_t  alu_view;
    wide_view_t wide_view;
  } lc4_insn_u;

  // Shared by CONST and the branch offset
  function automatic word_t sext_imm9(logic [8:0] imm9);
    return {{(WORD_W - 9){imm9[8]}}, imm9};
  endfunction

endpackage

`default_nettype wire

/* rtl/lc4_pipe_pkg.sv */
//##########################################################
// Pipeline definitions
// Reset PC, trace stall codes and NZP condition codes
//##########################################################
`default_nettype none

package lc4_pipe_pkg;

  localparam lc4_isa_pkg::word_t RESET_PC = 16'h8200;

  localparam logic [1:0] STALL_NONE  = 2'd0;
  localparam logic [1:0] STALL_FLUSH = 2'd2;

  localparam logic [2:0] NZP_NEG  = 3'b100;
  localparam logic [2:0] NZP_ZERO = 3'b010;
  localparam logic [2:0] NZP_POS  = 3'b001;

  // Condition codes of a result word, read as two's complement
  function automatic logic [2:0] nzp_from_result(lc4_isa_pkg::word_t value);
    if (value[lc4_isa_pkg::WORD_W-1]) return NZP_NEG;
    if (value == '0) return NZP_ZERO;
    return NZP_POS;
  endfunction

endpackage

`default_nettype wire

/* rtl/lc4_decoder.sv */
//##########################################################
// Instruction decoder
// Register selects, write enables and the branch flag
//##########################################################
`default_nettype none

module lc4_decoder (
  input  lc4_isa_pkg::lc4_insn_u i_insn,
  output lc4_isa_pkg::reg_sel_t  o_rs_sel,
  output lc4_isa_pkg::reg_sel_t  o_rt_sel,
  output lc4_isa_pkg::reg_sel_t  o_rd_sel,
  output logic                   o_regfile_we,
  output logic                   o_nzp_we,
  output logic                   o_is_branch
);

  logic alu_form_ok;

  // Register form is only ADD/AND with sub-op 00
  // Other sub-ops belong to operations this core does not run
  assign alu_form_ok = i_insn.alu_view.imm_flag || (i_insn.alu_view.low[4:3] == 2'b00);

  always_comb begin
    o_rs_sel     = i_insn.alu_view.rs;
    o_rt_sel     = i_insn.alu_view.low[2:0];
    o_rd_sel     = i_insn.alu_view.rd;
    o_regfile_we = 1'b0;
    o_nzp_we     = 1'b0;
    o_is_branch  = 1'b0;
    case (i_insn.alu_view.opcode)
      lc4_isa_pkg::OP_ADD,
      lc4_isa_pkg::OP_AND: begin
        o_regfile_we = alu_form_ok;
        o_nzp_we     = alu_form_ok;
      end
      lc4_isa_pkg::OP_CONST: begin
        o_rd_sel     = i_insn.wide_view.field;
        o_regfile_we = 1'b1;
        o_nzp_we     = 1'b1;
      end
      // NOP is a BR with an empty mask and is never taken
      lc4_isa_pkg::OP_BR: begin
        o_is_branch = 1'b1;
      end
      default: begin
        o_regfile_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/lc4_regfile.sv */
//##########################################################
// Register file, two read ports and one write port
// A same-cycle write is returned on the read ports
//##########################################################
`default_nettype none

module lc4_regfile #(
  parameter int DATA_W = 16,
  parameter int SEL_W  = 3,
  parameter int N_REGS = 8
) (
  input  logic              gwe,
  input  logic              i_reset,
  input  logic [SEL_W-1:0]  i_rs_sel,
  input  logic [SEL_W-1:0]  i_rt_sel,
  output logic [DATA_W-1:0] o_rs_data,
  output logic [DATA_W-1:0] o_rt_data,
  input  logic [SEL_W-1:0]  i_rd_sel,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_rd_we
);

  logic [DATA_W-1:0] regs [N_REGS];

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      for (int i = 0; i < N_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_we) begin
      regs[i_rd_sel] <= i_wdata;
    end
  end

  // WD bypass
  assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

/* rtl/lc4_operand_bypass.sv */
//##########################################################
// MX and WX bypass of the execute-stage operands
//##########################################################
`default_nettype none

module lc4_operand_bypass (
  input  lc4_isa_pkg::reg_sel_t i_rs_sel,
  input  lc4_isa_pkg::reg_sel_t i_rt_sel,
  input  lc4_isa_pkg::word_t    i_rs_data,
  input  lc4_isa_pkg::word_t    i_rt_data,
  input  lc4_isa_pkg::reg_sel_t i_mem_rd_sel,
  input  logic                  i_mem_we,
  input  lc4_isa_pkg::word_t    i_mem_result,
  input  lc4_isa_pkg::reg_sel_t i_wb_rd_sel,
  input  logic                  i_wb_we,
  input  lc4_isa_pkg::word_t    i_wb_result,
  output lc4_isa_pkg::word_t    o_rs_value,
  output lc4_isa_pkg::word_t    o_rt_value
);

  logic rs_mx, rs_wx, rt_mx, rt_wx;

  // Bubbles carry a cleared write enable and never match
  assign rs_mx = i_mem_we && (i_mem_rd_sel == i_rs_sel);
  assign rt_mx = i_mem_we && (i_mem_rd_sel == i_rt_sel);
  assign rs_wx = i_wb_we && (i_wb_rd_sel == i_rs_sel);
  assign rt_wx = i_wb_we && (i_wb_rd_sel == i_rt_sel);

  // Memory stage is younger, so it wins over writeback
  assign o_rs_value = rs_mx ? i_mem_result : (rs_wx ? i_wb_result : i_rs_data);
  assign o_rt_value = rt_mx ? i_mem_result : (rt_wx ? i_wb_result : i_rt_data);

endmodule

`default_nettype wire

/* rtl/lc4_alu.sv */
//##########################################################
// Execute-stage ALU for ADD, AND and CONST
//##########################################################
`default_nettype none

module lc4_alu (
  input  lc4_isa_pkg::lc4_insn_u i_insn,
  input  lc4_isa_pkg::word_t     i_rs_value,
  input  lc4_isa_pkg::word_t     i_rt_value,
  output lc4_isa_pkg::word_t     o_result
);

  lc4_isa_pkg::word_t imm5_sext;
  lc4_isa_pkg::word_t operand_b;
  logic               alu_form_ok;

  assign imm5_sext = {{(lc4_isa_pkg::WORD_W - 5){i_insn.alu_view.low[4]}},
                      i_insn.alu_view.low};

  // Second operand is rt or the immediate
  assign operand_b   = i_insn.alu_view.imm_flag ? imm5_sext : i_rt_value;
  assign alu_form_ok = i_insn.alu_view.imm_flag || (i_insn.alu_view.low[4:3] == 2'b00);

  always_comb begin
    case (i_insn.alu_view.opcode)
      lc4_isa_pkg::OP_ADD: begin
        o_result = alu_form_ok ? (i_rs_value + operand_b) : '0;
      end
      lc4_isa_pkg::OP_AND: begin
        o_result = alu_form_ok ? (i_rs_value & operand_b) : '0;
      end
      lc4_isa_pkg::OP_CONST: begin
        o_result = lc4_isa_pkg::sext_imm9(i_insn.wide_view.imm9);
      end
      // BR and anything unsupported
      default: begin
        o_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/lc4_pc_control.sv */
//##########################################################
// Fetch PC, NZP register and branch resolution
// NZP forwarding from memory and writeback, flush request
//##########################################################
`default_nettype none

module lc4_pc_control (
  input  logic                   gwe,
  input  logic                   i_reset,
  input  lc4_isa_pkg::lc4_insn_u i_insn,
  input  logic                   i_is_branch,
  input  logic                   i_mem_nzp_we,
  input  lc4_isa_pkg::word_t     i_mem_result,
  input  logic                   i_wb_nzp_we,
  input  logic [2:0]             i_wb_nzp_bits,
  output lc4_isa_pkg::word_t     o_cur_pc,
  output logic                   o_flush
);

  lc4_isa_pkg::word_t pc_q;
  lc4_isa_pkg::word_t dec_pc_q;
  lc4_isa_pkg::word_t ex_pc_q;
  lc4_isa_pkg::word_t branch_target;
  logic [2:0]         nzp_q;
  logic [2:0]         nzp_fwd;
  logic               taken;

  // Newest producer of NZP first
  assign nzp_fwd = i_mem_nzp_we ? lc4_pipe_pkg::nzp_from_result(i_mem_result) :
                   i_wb_nzp_we  ? i_wb_nzp_bits : nzp_q;

  assign taken         = i_is_branch && |(i_insn.wide_view.field & nzp_fwd);
  assign branch_target = ex_pc_q + lc4_isa_pkg::word_t'(1)
                         + lc4_isa_pkg::sext_imm9(i_insn.wide_view.imm9);

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      pc_q  <= lc4_pipe_pkg::RESET_PC;
      // No condition holds until the first NZP write
      nzp_q <= '0;
    end else begin
      pc_q <= taken ? branch_target : (pc_q + lc4_isa_pkg::word_t'(1));
      if (i_wb_nzp_we) begin
        nzp_q <= i_wb_nzp_bits;
      end
    end
  end

  // PC of the instructions now in decode and execute
  always_ff @(posedge gwe) begin
    dec_pc_q <= pc_q;
    ex_pc_q  <= dec_pc_q;
  end

  assign o_cur_pc = pc_q;
  assign o_flush  = taken;

endmodule

`default_nettype wire

/* rtl/lc4_processor.sv */
//##########################################################
// Five-stage LC4 pipeline top
// Stage registers, flush bubbles and writeback trace ports
//##########################################################
`default_nettype none

module lc4_processor (
  input  logic                  gwe,
  input  logic                  i_reset,
  output lc4_isa_pkg::word_t    o_cur_pc,
  input  lc4_isa_pkg::word_t    i_cur_insn,
  output logic [1:0]            o_test_stall,
  output lc4_isa_pkg::word_t    o_test_cur_pc,
  output lc4_isa_pkg::word_t    o_test_cur_insn,
  output logic                  o_test_regfile_we,
  output lc4_isa_pkg::reg_sel_t o_test_regfile_wsel,
  output lc4_isa_pkg::word_t    o_test_regfile_data,
  output logic                  o_test_nzp_we,
  output logic [2:0]            o_test_nzp_new_bits
);

  // Fetch decode
  lc4_isa_pkg::reg_sel_t  f_rs_sel, f_rt_sel, f_rd_sel;
  logic                   f_regfile_we, f_nzp_we, f_is_branch;
  // Decode stage
  lc4_isa_pkg::word_t     d_pc, d_insn;
  lc4_isa_pkg::reg_sel_t  d_rs_sel, d_rt_sel, d_rd_sel;
  logic                   d_regfile_we, d_nzp_we, d_is_branch;
  logic [1:0]             d_stall;
  lc4_isa_pkg::word_t     rf_rs_data, rf_rt_data;
  // Execute stage
  lc4_isa_pkg::word_t     x_pc, x_rs_data, x_rt_data;
  lc4_isa_pkg::lc4_insn_u x_insn;
  lc4_isa_pkg::reg_sel_t  x_rs_sel, x_rt_sel, x_rd_sel;
  logic                   x_regfile_we, x_nzp_we, x_is_branch;
  logic [1:0]             x_stall;
  lc4_isa_pkg::word_t     rs_value, rt_value, alu_result;
  logic                   flush;
  // Memory and writeback stages
  lc4_isa_pkg::word_t     m_pc, m_insn, m_result;
  lc4_isa_pkg::reg_sel_t  m_rd_sel;
  logic                   m_regfile_we, m_nzp_we;
  logic [1:0]             m_stall;
  lc4_isa_pkg::word_t     w_pc, w_insn, w_result;
  lc4_isa_pkg::reg_sel_t  w_rd_sel;
  logic                   w_regfile_we, w_nzp_we;
  logic [1:0]             w_stall;
  logic [2:0]             w_nzp_bits;

  lc4_decoder lc4_decoder_inst (
    .i_insn       (lc4_isa_pkg::lc4_insn_u'(i_cur_insn)),
    .o_rs_sel     (f_rs_sel),
    .o_rt_sel     (f_rt_sel),
    .o_rd_sel     (f_rd_sel),
    .o_regfile_we (f_regfile_we),
    .o_nzp_we     (f_nzp_we),
    .o_is_branch  (f_is_branch)
  );

  lc4_regfile #(
    .DATA_W (lc4_isa_pkg::WORD_W),
    .SEL_W  (lc4_isa_pkg::REG_SEL_W),
    .N_REGS (lc4_isa_pkg::NUM_REGS)
  ) lc4_regfile_inst (
    .gwe       (gwe),
    .i_reset   (i_reset),
    .i_rs_sel  (d_rs_sel),
    .i_rt_sel  (d_rt_sel),
    .o_rs_data (rf_rs_data),
    .o_rt_data (rf_rt_data),
    .i_rd_sel  (w_rd_sel),
    .i_wdata   (w_result),
    .i_rd_we   (w_regfile_we)
  );

  lc4_operand_bypass lc4_operand_bypass_inst (
    .i_rs_sel     (x_rs_sel),
    .i_rt_sel     (x_rt_sel),
    .i_rs_data    (x_rs_data),
    .i_rt_data    (x_rt_data),
    .i_mem_rd_sel (m_rd_sel),
    .i_mem_we     (m_regfile_we),
    .i_mem_result (m_result),
    .i_wb_rd_sel  (w_rd_sel),
    .i_wb_we      (w_regfile_we),
    .i_wb_result  (w_result),
    .o_rs_value   (rs_value),
    .o_rt_value   (rt_value)
  );

  lc4_alu lc4_alu_inst (
    .i_insn     (x_insn),
    .i_rs_value (rs_value),
    .i_rt_value (rt_value),
    .o_result   (alu_result)
  );

  lc4_pc_control lc4_pc_control_inst (
    .gwe           (gwe),
    .i_reset       (i_reset),
    .i_insn        (x_insn),
    .i_is_branch   (x_is_branch),
    .i_mem_nzp_we  (m_nzp_we),
    .i_mem_result  (m_result),
    .i_wb_nzp_we   (w_nzp_we),
    .i_wb_nzp_bits (w_nzp_bits),
    .o_cur_pc      (o_cur_pc),
    .o_flush       (flush)
  );

  // Decode and execute turn into NOP bubbles on reset or a taken branch
  always_ff @(posedge gwe) begin
    if (i_reset || flush) begin
      d_insn       <= '0;
      d_regfile_we <= 1'b0;
      d_nzp_we     <= 1'b0;
      d_is_branch  <= 1'b0;
      d_stall      <= lc4_pipe_pkg::STALL_FLUSH;
      x_insn       <= '0;
      x_regfile_we <= 1'b0;
      x_nzp_we     <= 1'b0;
      x_is_branch  <= 1'b0;
      x_stall      <= lc4_pipe_pkg::STALL_FLUSH;
    end else begin
      d_insn       <= i_cur_insn;
      d_regfile_we <= f_regfile_we;
      d_nzp_we     <= f_nzp_we;
      d_is_branch  <= f_is_branch;
      d_stall      <= lc4_pipe_pkg::STALL_NONE;
      x_insn       <= d_insn;
      x_regfile_we <= d_regfile_we;
      x_nzp_we     <= d_nzp_we;
      x_is_branch  <= d_is_branch;
      x_stall      <= d_stall;
    end
  end

  // Memory is a plain pipeline stage here
  always_ff @(posedge gwe) begin
    if (i_reset) begin
      m_insn       <= '0;
      m_regfile_we <= 1'b0;
      m_nzp_we     <= 1'b0;
      m_stall      <= lc4_pipe_pkg::STALL_FLUSH;
      w_insn       <= '0;
      w_regfile_we <= 1'b0;
      w_nzp_we     <= 1'b0;
      w_stall      <= lc4_pipe_pkg::STALL_FLUSH;
    end else begin
      m_insn       <= x_insn;
      m_regfile_we <= x_regfile_we;
      m_nzp_we     <= x_nzp_we;
      m_stall      <= x_stall;
      w_insn       <= m_insn;
      w_regfile_we <= m_regfile_we;
      w_nzp_we     <= m_nzp_we;
      w_stall      <= m_stall;
    end
  end

  always_ff @(posedge gwe) begin
    d_pc      <= o_cur_pc;
    d_rs_sel  <= f_rs_sel;
    d_rt_sel  <= f_rt_sel;
    d_rd_sel  <= f_rd_sel;
    x_pc      <= d_pc;
    x_rs_sel  <= d_rs_sel;
    x_rt_sel  <= d_rt_sel;
    x_rd_sel  <= d_rd_sel;
    x_rs_data <= rf_rs_data;
    x_rt_data <= rf_rt_data;
    m_pc      <= x_pc;
    m_rd_sel  <= x_rd_sel;
    m_result  <= alu_result;
    w_pc      <= m_pc;
    w_rd_sel  <= m_rd_sel;
    w_result  <= m_result;
  end

  assign w_nzp_bits = lc4_pipe_pkg::nzp_from_result(w_result);

  // Writeback trace
  assign o_test_stall        = w_stall;
  assign o_test_cur_pc       = w_pc;
  assign o_test_cur_insn     = w_insn;
  assign o_test_regfile_we   = w_regfile_we;
  assign o_test_regfile_wsel = w_rd_sel;
  assign o_test_regfile_data = w_result;
  assign o_test_nzp_we       = w_nzp_we;
  assign o_test_nzp_new_bits = w_nzp_bits;

endmodule

`default_nettype wire

/* include/lc4_test_program.svh */
//##########################################################
// Test program image, first word at the reset PC
// Bypass distances 1 to 3, taken and not-taken branches
//##########################################################
`ifndef LC4_TEST_PROGRAM_SVH
`define LC4_TEST_PROGRAM_SVH

localparam int TEST_PROGRAM_LEN = 25;

localparam logic [15:0] TEST_PROGRAM [TEST_PROGRAM_LEN] = '{
  // CONST R0,#5 / CONST R1,#-3 / ADD R2,R0,R1 / ADD R3,R2,R2
  16'h9005, 16'h93FD, 16'h1401, 16'h1682,
  // AND R4,R2,R3 / ADD R5,R2,#-5 (distance 3) / ADD R6,R0,#-1
  16'h5883, 16'h1ABB, 16'h1C3F,
  // BRp +2 taken, only the memory stage holds a positive NZP
  16'h0202, 16'h9E01, 16'h9E02,
  // ADD R7,R1,#0 / NOP / BRn +1 taken with NZP from writeback
  16'h1E60, 16'h0000, 16'h0801, 16'h9E07,
  // AND R0,R0,#0 / ADD R1,R1,#3 / BRnp +5 falls through
  16'h5020, 16'h1263, 16'h0A05,
  // CONST R2,#-256 then two NOPs
  16'h9500, 16'h0000, 16'h0000,
  // BRz +3 falls through, BRn +1 taken, both from the NZP register
  16'h0403, 16'h0801, 16'h9609,
  // ADD R3,R2,R2 / AND R5,R3,R5 is the final instruction
  16'h1682, 16'h5AC5
};

`endif

/* dv/lc4_processor_tb.sv */
//##########################################################
// Testbench for the five-stage LC4 pipeline
// Clock, reset, instruction memory, ISA reference model
// and a checker on the writeback trace ports
//##########################################################
`default_nettype none

module lc4_processor_tb;

  timeunit 1ns;
  timeprecision 1ps;

  `include "lc4_test_program.svh"

  localparam int RETIRE_TIMEOUT = 200;

  logic        gwe;
  logic        i_reset;
  logic [15:0] o_cur_pc;
  logic [15:0] i_cur_insn;
  logic [1:0]  o_test_stall;
  logic [15:0] o_test_cur_pc;
  logic [15:0] o_test_cur_insn;
  logic        o_test_regfile_we;
  logic [2:0]  o_test_regfile_wsel;
  logic [15:0] o_test_regfile_data;
  logic        o_test_nzp_we;
  logic [2:0]  o_test_nzp_new_bits;

  // Instruction memory, answers in the same cycle
  logic [15:0] imem [65536];

  // Architectural model state
  logic [15:0] ref_regs [8];
  logic [15:0] ref_pc;
  logic [2:0]  ref_nzp;
  logic [15:0] last_pc;
  int          flushes_left;
  logic        checking;
  logic        run_done;
  int          seed;

  lc4_processor lc4_processor_inst (
    .gwe                 (gwe),
    .i_reset             (i_reset),
    .o_cur_pc            (o_cur_pc),
    .i_cur_insn          (i_cur_insn),
    .o_test_stall        (o_test_stall),
    .o_test_cur_pc       (o_test_cur_pc),
    .o_test_cur_insn     (o_test_cur_insn),
    .o_test_regfile_we   (o_test_regfile_we),
    .o_test_regfile_wsel (o_test_regfile_wsel),
    .o_test_regfile_data (o_test_regfile_data),
    .o_test_nzp_we       (o_test_nzp_we),
    .o_test_nzp_new_bits (o_test_nzp_new_bits)
  );

  assign i_cur_insn = imem[o_cur_pc];

  always #4 gwe = ~gwe;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic logic [2:0] expected_nzp(input logic [15:0] value);
    if (value[15]) begin
      return lc4_pipe_pkg::NZP_NEG;
    end
    if (value == 16'h0000) begin
      return lc4_pipe_pkg::NZP_ZERO;
    end
    return lc4_pipe_pkg::NZP_POS;
  endfunction

  // Executes the instruction at ref_pc and advances the model
  function automatic void step_reference(
    output logic [15:0] e_pc,
    output logic [15:0] e_insn,
    output logic        e_we,
    output logic [2:0]  e_rd,
    output logic [15:0] e_data,
    output logic        e_nzp_we,
    output logic [2:0]  e_nzp,
    output logic        e_taken
  );
    logic [15:0] insn;
    logic [15:0] src_b;
    logic [15:0] imm9;
    logic [15:0] next_pc;
    logic        form_ok;
    insn     = imem[ref_pc];
    e_pc     = ref_pc;
    e_insn   = insn;
    e_we     = 1'b0;
    e_rd     = insn[11:9];
    e_data   = 16'h0000;
    e_nzp_we = 1'b0;
    e_nzp    = 3'b000;
    e_taken  = 1'b0;
    imm9     = {{7{insn[8]}}, insn[8:0]};
    src_b    = insn[5] ? {{11{insn[4]}}, insn[4:0]} : ref_regs[insn[2:0]];
    form_ok  = insn[5] || (insn[4:3] == 2'b00);
    next_pc  = ref_pc + 16'd1;
    case (insn[15:12])
      lc4_isa_pkg::OP_ADD: begin
        e_we   = form_ok;
        e_data = ref_regs[insn[8:6]] + src_b;
      end
      lc4_isa_pkg::OP_AND: begin
        e_we   = form_ok;
        e_data = ref_regs[insn[8:6]] & src_b;
      end
      lc4_isa_pkg::OP_CONST: begin
        e_we   = 1'b1;
        e_data = imm9;
      end
      lc4_isa_pkg::OP_BR: begin
        if (|(insn[11:9] & ref_nzp)) begin
          e_taken = 1'b1;
          next_pc = next_pc + imm9;
        end
      end
      default: begin
        e_we = 1'b0;
      end
    endcase
    if (e_we) begin
      e_nzp_we       = 1'b1;
      e_nzp          = expected_nzp(e_data);
      ref_regs[e_rd] = e_data;
      ref_nzp        = e_nzp;
    end
    ref_pc = next_pc;
  endfunction

  task automatic compare_retirement();
    logic [15:0] e_pc, e_insn, e_data;
    logic [2:0]  e_rd, e_nzp;
    logic        e_we, e_nzp_we, e_taken;
    if (flushes_left > 0) begin
      // Bubbles behind a taken branch
      check_value("o_test_stall", 16'(o_test_stall), 16'(lc4_pipe_pkg::STALL_FLUSH));
      check_value("o_test_regfile_we", 16'(o_test_regfile_we), 16'h0000);
      check_value("o_test_nzp_we", 16'(o_test_nzp_we), 16'h0000);
      flushes_left--;
    end else begin
      step_reference(e_pc, e_insn, e_we, e_rd, e_data, e_nzp_we, e_nzp, e_taken);
      check_value("o_test_stall", 16'(o_test_stall), 16'(lc4_pipe_pkg::STALL_NONE));
      check_value("o_test_cur_pc", o_test_cur_pc, e_pc);
      check_value("o_test_cur_insn", o_test_cur_insn, e_insn);
      check_value("o_test_regfile_we", 16'(o_test_regfile_we), 16'(e_we));
      if (e_we) begin
        check_value("o_test_regfile_wsel", 16'(o_test_regfile_wsel), 16'(e_rd));
        check_value("o_test_regfile_data", o_test_regfile_data, e_data);
      end
      check_value("o_test_nzp_we", 16'(o_test_nzp_we), 16'(e_nzp_we));
      if (e_nzp_we) begin
        check_value("o_test_nzp_new_bits", 16'(o_test_nzp_new_bits), 16'(e_nzp));
      end
      if (e_taken) begin
        flushes_left = 2;
      end
      if (e_pc == last_pc) begin
        run_done = 1'b1;
      end
    end
  endtask

  always @(negedge gwe) begin
    if (checking) begin
      compare_retirement();
    end
  end

  task automatic load_program(input bit random_imm);
    logic [15:0] addr;
    logic [15:0] word;
    for (int i = 0; i < 65536; i++) begin
      imem[i] = 16'h0000;
    end
    for (int i = 0; i < TEST_PROGRAM_LEN; i++) begin
      addr = lc4_pipe_pkg::RESET_PC + 16'(i);
      word = TEST_PROGRAM[i];
      if (random_imm && (word[15:12] == lc4_isa_pkg::OP_CONST)) begin
        word[8:0] = 9'($random(seed));
      end else if (random_imm && word[5] && ((word[15:12] == lc4_isa_pkg::OP_ADD) ||
                                             (word[15:12] == lc4_isa_pkg::OP_AND))) begin
        word[4:0] = 5'($random(seed));
      end
      imem[addr] = word;
    end
  endtask

  task automatic run_program(input bit random_imm);
    int cyc;
    @(posedge gwe);
    checking <= 1'b0;
    i_reset  <= 1'b1;
    load_program(random_imm);
    for (int r = 0; r < 8; r++) begin
      ref_regs[r] = 16'h0000;
    end
    ref_pc       = lc4_pipe_pkg::RESET_PC;
    ref_nzp      = 3'b000;
    last_pc      = lc4_pipe_pkg::RESET_PC + 16'(TEST_PROGRAM_LEN - 1);
    flushes_left = 0;
    run_done     = 1'b0;
    repeat (2) @(posedge gwe);
    i_reset <= 1'b0;
    // Pipeline fill after reset
    for (int i = 0; i < 4; i++) begin
      @(negedge gwe);
      if (i == 0) begin
        check_value("o_cur_pc", o_cur_pc, lc4_pipe_pkg::RESET_PC);
      end
      check_value("o_test_stall", 16'(o_test_stall), 16'(lc4_pipe_pkg::STALL_FLUSH));
      check_value("o_test_regfile_we", 16'(o_test_regfile_we), 16'h0000);
      check_value("o_test_nzp_we", 16'(o_test_nzp_we), 16'h0000);
    end
    @(posedge gwe);
    checking = 1'b1;
    for (cyc = 0; (cyc < RETIRE_TIMEOUT) && !run_done; cyc++) begin
      @(posedge gwe);
    end
    checking = 1'b0;
    if (!run_done) begin
      fail_run("timeout: the final instruction did not retire within 200 cycles");
    end
  endtask

  initial begin
    seed     = 32'h8eff8a40;
    gwe      = 1'b0;
    i_reset  = 1'b1;
    checking = 1'b0;
    run_done = 1'b0;
    // Fixed program, then the same program with random immediates
    run_program(1'b0);
    run_program(1'b1);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* lc4_processor.f */
+incdir+include
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_operand_bypass.sv
rtl/lc4_alu.sv
rtl/lc4_pc_control.sv
rtl/lc4_processor.sv
dv/lc4_processor_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f lc4_processor.f \
		--top-module lc4_processor_tb -Mdir obj_dir
	./obj_dir/Vlc4_processor_tb > sim.log 2>&1; cat sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
